// File: Bender.yml
package:
  name: miss_unit

sources:
  - include_dirs:
      - src
    files:
      - src/miss_queue_pkg.sv
      - src/miss_fifo.sv
      - src/refill_requester.sv
      - src/miss_replay_ctrl.sv
      - src/miss_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/miss_unit_checker.sv
      - test/tb_miss_unit.sv

// File: src/miss_fifo.sv
/*
 * Miss FIFO with read, write and checkpoint pointers.
 * Misses are written in order. The reader dequeues, skips or invalidates
 * the entry at the read pointer, and a rollback returns the read pointer
 * to the checkpoint, which marks the oldest live entry. In dequeue mode
 * holes at the head are passed and the checkpoint follows the reader.
 */
`include "miss_queue_macros.svh"

module miss_fifo (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic [`MQ_ENTRY_W-1:0]        data_i,
  input  logic                          v_i,
  output logic                          ready_o,

  output logic                          v_o,
  output logic [`MQ_ENTRY_W-1:0]        data_o,
  input  logic                          yumi_i,
  input  miss_queue_pkg::miss_fifo_op_e yumi_op_i,
  input  logic                          scan_not_dq_i,

  input  logic                          rollback_i,
  output logic                          empty_o,
  output logic                          at_tail_o
);

  import miss_queue_pkg::*;

  localparam int els_lp   = `MQ_ELS;
  localparam int ptr_w_lp = (els_lp > 1) ? $clog2(els_lp) : 1;

  logic [`MQ_ENTRY_W-1:0] mem_r [els_lp];
  logic [els_lp-1:0]      valid_r;
  logic [ptr_w_lp-1:0]    read_ptr_r;
  logic [ptr_w_lp-1:0]    write_ptr_r;
  logic [ptr_w_lp-1:0]    cp_ptr_r;
  // read pointer has moved past the checkpoint in this scan
  logic                   ahead_r;

  logic full;
  logic empty;
  logic enque;
  logic inval;
  logic read_inc;
  logic cp_inc;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(els_lp - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // checkpoint and write pointer equal, valid bit tells full from empty
  assign full  = (cp_ptr_r == write_ptr_r) & valid_r[write_ptr_r];
  assign empty = (cp_ptr_r == write_ptr_r) & ~valid_r[write_ptr_r];

  assign ready_o   = ~full;
  assign empty_o   = empty;
  assign at_tail_o = (read_ptr_r == write_ptr_r);
  assign enque     = v_i & ~full;

  // a reader that went all the way round a full ring sees nothing new
  assign v_o    = valid_r[read_ptr_r] & ~(ahead_r & at_tail_o);
  assign data_o = mem_r[read_ptr_r];

  always_comb begin
    inval    = 1'b0;
    read_inc = 1'b0;
    cp_inc   = 1'b0;
    if (!rollback_i) begin
      if (v_o) begin
        if (yumi_i) begin
          read_inc = 1'b1;
          case (yumi_op_i)
            e_miss_fifo_dequeue: begin
              inval  = 1'b1;
              cp_inc = 1'b1;
            end
            e_miss_fifo_invalidate: begin
              inval = 1'b1;
            end
            default: begin
              inval = 1'b0;
            end
          endcase
        end
      end else if (!at_tail_o) begin
        // pass a hole
        read_inc = 1'b1;
        cp_inc   = ~scan_not_dq_i | (read_ptr_r == cp_ptr_r);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      read_ptr_r  <= '0;
      write_ptr_r <= '0;
      cp_ptr_r    <= '0;
      valid_r     <= '0;
      ahead_r     <= 1'b0;
    end else begin
      if (rollback_i) begin
        read_ptr_r <= cp_ptr_r;
      end else if (read_inc) begin
        read_ptr_r <= next_ptr(read_ptr_r);
      end

      if (cp_inc) begin
        cp_ptr_r <= next_ptr(cp_ptr_r);
      end

      if (enque) begin
        write_ptr_r <= next_ptr(write_ptr_r);
      end

      if (rollback_i) begin
        ahead_r <= 1'b0;
      end else if (read_inc && !cp_inc) begin
        ahead_r <= 1'b1;
      end

      // enque and inval never hit the same slot, full blocks the write
      if (enque) begin
        valid_r[write_ptr_r] <= 1'b1;
      end
      if (inval) begin
        valid_r[read_ptr_r] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enque) begin
      mem_r[write_ptr_r] <= data_i;
    end
  end

  // reader contract with the replay controller
  yumi_rollback_excl_a: assert property (
    @(posedge clk_i) disable iff (!reset_i) !(yumi_i && rollback_i)
  ) else $error("yumi_i and rollback_i high together");

  yumi_needs_v_a: assert property (
    @(posedge clk_i) disable iff (!reset_i) yumi_i |-> v_o
  ) else $error("yumi_i raised while v_o is low");

endmodule

// File: src/miss_queue_macros.svh
/*
 * Sizes shared by the miss unit RTL and its testbench.
 * Include this in any file that declares a miss entry, a cache line
 * or a response word.
 */
`ifndef MISS_QUEUE_MACROS_SVH
`define MISS_QUEUE_MACROS_SVH

// miss FIFO depth
`define MQ_ELS 8

// block address and word offset inside a line
`define MQ_BLOCK_W 16
`define MQ_OFFSET_W 2

`define MQ_ID_W 4
`define MQ_WORD_W 32

// four words per line
`define MQ_LINE_W (`MQ_WORD_W * (1 << `MQ_OFFSET_W))

// packed miss entry {block, offset, id}
`define MQ_ENTRY_W (`MQ_BLOCK_W + `MQ_OFFSET_W + `MQ_ID_W)

`endif

// File: src/miss_queue_pkg.sv
/*
 * Types for the miss unit.
 * The FIFO operation selects what happens to the entry at the read
 * pointer when the replay controller takes it. The replay state is
 * the controller's FSM encoding.
 */
package miss_queue_pkg;

  // operation on the entry at the read pointer
  typedef enum logic [1:0] {
    e_miss_fifo_dequeue,
    e_miss_fifo_skip,
    e_miss_fifo_invalidate
  } miss_fifo_op_e;

  // replay controller states
  typedef enum logic [2:0] {
    e_replay_idle,
    // refill of the head block in flight
    e_replay_refill,
    // one entry per cycle against the refilled block
    e_replay_scan,
    e_replay_rollback,
    // pass invalidated holes at the head
    e_replay_drain
  } replay_state_e;

endpackage

// File: src/miss_replay_ctrl.sv
/*
 * Replay FSM for the miss FIFO.
 * Refills the block of the oldest miss, then scans the FIFO once. A hit
 * at the head is dequeued, a hit behind a skipped entry is invalidated,
 * anything else is skipped. Every hit loads the response register.
 * At the tail the read pointer is rolled back and holes are drained.
 */
`include "miss_queue_macros.svh"

module miss_replay_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic                          fifo_v_i,
  input  logic [`MQ_ENTRY_W-1:0]        fifo_data_i,
  input  logic                          fifo_empty_i,
  input  logic                          fifo_at_tail_i,
  output logic                          yumi_o,
  output miss_queue_pkg::miss_fifo_op_e yumi_op_o,
  output logic                          scan_not_dq_o,
  output logic                          rollback_o,

  output logic                          refill_start_o,
  output logic [`MQ_BLOCK_W-1:0]        refill_block_o,
  input  logic                          refill_busy_i,
  input  logic [`MQ_LINE_W-1:0]         line_i,

  output logic                          resp_v_o,
  input  logic                          resp_ready_i,
  output logic [`MQ_ID_W-1:0]           resp_id_o,
  output logic [`MQ_WORD_W-1:0]         resp_data_o
);

  import miss_queue_pkg::*;

  replay_state_e state_r;
  replay_state_e state_n;

  logic [`MQ_BLOCK_W-1:0]  block_r;
  // an entry was skipped in this scan
  logic                    skipped_r;
  logic                    resp_v_r;
  logic [`MQ_ID_W-1:0]     resp_id_r;
  logic [`MQ_WORD_W-1:0]   resp_data_r;

  logic [`MQ_BLOCK_W-1:0]  entry_block;
  logic [`MQ_OFFSET_W-1:0] entry_offset;
  logic [`MQ_ID_W-1:0]     entry_id;
  logic                    match;
  logic                    resp_stall;
  logic                    resp_load;

  assign entry_block  = fifo_data_i[`MQ_ENTRY_W-1 -: `MQ_BLOCK_W];
  assign entry_offset = fifo_data_i[`MQ_ID_W +: `MQ_OFFSET_W];
  assign entry_id     = fifo_data_i[`MQ_ID_W-1:0];

  assign match      = (entry_block == block_r);
  assign resp_stall = resp_v_r & ~resp_ready_i;

  assign refill_block_o = entry_block;
  assign resp_v_o       = resp_v_r;
  assign resp_id_o      = resp_id_r;
  assign resp_data_o    = resp_data_r;

  always_comb begin
    state_n        = state_r;
    yumi_o         = 1'b0;
    yumi_op_o      = e_miss_fifo_skip;
    scan_not_dq_o  = 1'b0;
    rollback_o     = 1'b0;
    refill_start_o = 1'b0;
    resp_load      = 1'b0;
    case (state_r)
      e_replay_idle: begin
        if (fifo_v_i) begin
          refill_start_o = 1'b1;
          state_n        = e_replay_refill;
        end
      end
      e_replay_refill: begin
        if (!refill_busy_i) begin
          state_n = e_replay_scan;
        end
      end
      e_replay_scan: begin
        scan_not_dq_o = 1'b1;
        if (fifo_v_i) begin
          // hold the entry while the last response is back-pressured
          if (!resp_stall) begin
            yumi_o = 1'b1;
            if (match) begin
              yumi_op_o = skipped_r ? e_miss_fifo_invalidate : e_miss_fifo_dequeue;
              resp_load = 1'b1;
            end
          end
        end else if (fifo_at_tail_i) begin
          state_n = e_replay_rollback;
        end
      end
      e_replay_rollback: begin
        rollback_o = 1'b1;
        state_n    = e_replay_drain;
      end
      e_replay_drain: begin
        if (fifo_v_i || fifo_empty_i) begin
          state_n = e_replay_idle;
        end
      end
      default: begin
        state_n = e_replay_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_r   <= e_replay_idle;
      skipped_r <= 1'b0;
      resp_v_r  <= 1'b0;
    end else begin
      state_r <= state_n;

      if (state_r == e_replay_refill) begin
        skipped_r <= 1'b0;
      end else if (yumi_o && !match) begin
        skipped_r <= 1'b1;
      end

      if (resp_load) begin
        resp_v_r <= 1'b1;
      end else if (resp_ready_i) begin
        resp_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_start_o) begin
      block_r <= entry_block;
    end
    if (resp_load) begin
      resp_id_r   <= entry_id;
      resp_data_r <= line_i[entry_offset * `MQ_WORD_W +: `MQ_WORD_W];
    end
  end

  no_yumi_on_pending_resp_a: assert property (
    @(posedge clk_i) disable iff (!reset_i) yumi_o |-> !resp_v_o || resp_ready_i
  ) else $error("yumi issued while a response is pending");

endmodule

// File: src/miss_unit.sv
/*
 * Miss tracking unit of the non-blocking data cache.
 * Load misses go into the miss FIFO. The replay controller refills one
 * line at a time over the four-phase memory port and returns one
 * response per miss with its id and requested word.
 */
`include "miss_queue_macros.svh"

module miss_unit (
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic                    miss_v_i,
  output logic                    miss_ready_o,
  input  logic [`MQ_BLOCK_W-1:0]  miss_block_i,
  input  logic [`MQ_OFFSET_W-1:0] miss_offset_i,
  input  logic [`MQ_ID_W-1:0]     miss_id_i,

  output logic                    mem_req_o,
  output logic [`MQ_BLOCK_W-1:0]  mem_block_o,
  input  logic                    mem_ack_i,
  input  logic [`MQ_LINE_W-1:0]   mem_line_i,

  output logic                    resp_v_o,
  input  logic                    resp_ready_i,
  output logic [`MQ_ID_W-1:0]     resp_id_o,
  output logic [`MQ_WORD_W-1:0]   resp_data_o
);

  import miss_queue_pkg::*;

  logic                   fifo_v;
  logic [`MQ_ENTRY_W-1:0] fifo_data;
  logic                   fifo_empty;
  logic                   fifo_at_tail;
  logic                   yumi;
  miss_fifo_op_e          yumi_op;
  logic                   scan_not_dq;
  logic                   rollback;
  logic                   refill_start;
  logic [`MQ_BLOCK_W-1:0] refill_block;
  logic                   refill_busy;
  logic [`MQ_LINE_W-1:0]  refill_line;

  miss_fifo fifo_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .data_i       ({miss_block_i, miss_offset_i, miss_id_i}),
    .v_i          (miss_v_i),
    .ready_o      (miss_ready_o),
    .v_o          (fifo_v),
    .data_o       (fifo_data),
    .yumi_i       (yumi),
    .yumi_op_i    (yumi_op),
    .scan_not_dq_i(scan_not_dq),
    .rollback_i   (rollback),
    .empty_o      (fifo_empty),
    .at_tail_o    (fifo_at_tail)
  );

  refill_requester requester_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (refill_start),
    .block_i    (refill_block),
    .busy_o     (refill_busy),
    .line_o     (refill_line),
    .mem_req_o  (mem_req_o),
    .mem_block_o(mem_block_o),
    .mem_ack_i  (mem_ack_i),
    .mem_line_i (mem_line_i)
  );

  miss_replay_ctrl ctrl_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fifo_v_i      (fifo_v),
    .fifo_data_i   (fifo_data),
    .fifo_empty_i  (fifo_empty),
    .fifo_at_tail_i(fifo_at_tail),
    .yumi_o        (yumi),
    .yumi_op_o     (yumi_op),
    .scan_not_dq_o (scan_not_dq),
    .rollback_o    (rollback),
    .refill_start_o(refill_start),
    .refill_block_o(refill_block),
    .refill_busy_i (refill_busy),
    .line_i        (refill_line),
    .resp_v_o      (resp_v_o),
    .resp_ready_i  (resp_ready_i),
    .resp_id_o     (resp_id_o),
    .resp_data_o   (resp_data_o)
  );

endmodule

// File: src/refill_requester.sv
/*
 * Four-phase req/ack master for line refills.
 * A pulse on start_i latches the block and raises the request. The line
 * is captured on the first cycle ack is seen high, the request then
 * drops, and busy stays high until ack falls. The line is held until
 * the next start.
 */
`include "miss_queue_macros.svh"

module refill_requester (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  logic                   start_i,
  input  logic [`MQ_BLOCK_W-1:0] block_i,
  output logic                   busy_o,
  output logic [`MQ_LINE_W-1:0]  line_o,

  output logic                   mem_req_o,
  output logic [`MQ_BLOCK_W-1:0] mem_block_o,
  input  logic                   mem_ack_i,
  input  logic [`MQ_LINE_W-1:0]  mem_line_i
);

  logic                   req_r;
  // line captured and waiting for ack to fall
  logic                   ack_wait_r;
  logic [`MQ_BLOCK_W-1:0] block_r;
  logic [`MQ_LINE_W-1:0]  line_r;

  assign busy_o      = req_r | ack_wait_r;
  assign mem_req_o   = req_r;
  assign mem_block_o = block_r;
  assign line_o      = line_r;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      req_r      <= 1'b0;
      ack_wait_r <= 1'b0;
    end else if (start_i && !busy_o) begin
      req_r <= 1'b1;
    end else if (req_r && mem_ack_i) begin
      req_r      <= 1'b0;
      ack_wait_r <= 1'b1;
    end else if (ack_wait_r && !mem_ack_i) begin
      ack_wait_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_o) begin
      block_r <= block_i;
    end
    if (req_r && mem_ack_i) begin
      line_r <= mem_line_i;
    end
  end

  req_holds_a: assert property (
    @(posedge clk_i) disable iff (!reset_i) mem_req_o && !mem_ack_i |=> mem_req_o
  ) else $error("mem_req_o dropped before mem_ack_i");

endmodule

// File: test/miss_unit_checker.sv
/*
 * Checker for the miss unit testbench.
 * Samples the DUT ports on the rising edge and keeps every outstanding
 * miss by id. Compares response words, response order, the memory
 * handshake and the full flag against the miss unit rules, and counts
 * the errors for the testbench top to report.
 */
`include "miss_queue_macros.svh"

module miss_unit_checker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    miss_v_i,
  input  logic                    miss_ready_i,
  input  logic [`MQ_BLOCK_W-1:0]  miss_block_i,
  input  logic [`MQ_OFFSET_W-1:0] miss_offset_i,
  input  logic [`MQ_ID_W-1:0]     miss_id_i,
  input  logic                    mem_req_i,
  input  logic [`MQ_BLOCK_W-1:0]  mem_block_i,
  input  logic                    mem_ack_i,
  input  logic                    resp_v_i,
  input  logic                    resp_ready_i,
  input  logic [`MQ_ID_W-1:0]     resp_id_i,
  input  logic [`MQ_WORD_W-1:0]   resp_data_i,
  input  logic                    final_check_i,
  output int                      outstanding_o,
  output int                      mismatch_count_o,
  output int                      failure_count_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ids_lp = 1 << `MQ_ID_W;

  // reference model with one slot per id
  logic                    out_v      [ids_lp];
  logic [`MQ_BLOCK_W-1:0]  out_block  [ids_lp];
  logic [`MQ_OFFSET_W-1:0] out_offset [ids_lp];
  int                      out_seq    [ids_lp];
  int                      seq_cnt;

  logic                    reset_checked;
  logic                    have_prev;
  logic                    prev_req;
  logic                    prev_ack;
  logic [`MQ_BLOCK_W-1:0]  prev_block;
  logic                    prev_resp_v;
  logic                    prev_resp_ready;
  logic [`MQ_ID_W-1:0]     prev_resp_id;
  logic [`MQ_WORD_W-1:0]   prev_resp_data;

  // block of the last refill and the miss count at its ack
  logic                    have_refill;
  logic [`MQ_BLOCK_W-1:0]  last_block;
  int                      ack_seq;

  task automatic record_mismatch(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    mismatch_count_o++;
    $display("Mismatch test=%s expected=0x%0h actual=0x%0h at %0t",
             test_name, expected, actual, $time);
  endtask

  task automatic flag_failure(input string what);
    failure_count_o++;
    $display("Error at %0t: %s", $time, what);
  endtask

  // a new request must fetch the oldest miss still waiting in the FIFO
  task automatic check_request();
    int oldest;
    int i;
    oldest = -1;
    for (i = 0; i < ids_lp; i++) begin
      if (out_v[i] && !(resp_v_i && resp_id_i == i)) begin
        if (oldest < 0 || out_seq[i] < out_seq[oldest]) begin
          oldest = i;
        end
        if (have_refill && out_block[i] == last_block && out_seq[i] < ack_seq) begin
          flag_failure($sformatf("miss id %0d to block 0x%0h was left out of its scan",
                                 i, last_block));
        end
      end
    end
    if (oldest < 0) begin
      flag_failure("memory request issued with no outstanding miss");
    end else if (mem_block_i !== out_block[oldest]) begin
      record_mismatch("mem_block_oldest", out_block[oldest], mem_block_i);
    end
  endtask

  always @(posedge clk_i) begin
    int                    i;
    logic [`MQ_WORD_W-1:0] exp_word;
    if (!reset_i) begin
      for (i = 0; i < ids_lp; i++) begin
        out_v[i] = 1'b0;
      end
      outstanding_o = 0;
      seq_cnt       = 0;
      reset_checked = 1'b0;
      have_prev     = 1'b0;
      have_refill   = 1'b0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (mem_req_i !== 1'b0) begin
          record_mismatch("reset_mem_req", 0, mem_req_i);
        end
        if (resp_v_i !== 1'b0) begin
          record_mismatch("reset_resp_v", 0, resp_v_i);
        end
        if (miss_ready_i !== 1'b1) begin
          record_mismatch("reset_miss_ready", 1, miss_ready_i);
        end
      end

      // in a stalled refill with no response pending the FIFO holds every miss
      if (mem_req_i && !mem_ack_i && !resp_v_i && outstanding_o >= `MQ_ELS &&
          miss_ready_i !== 1'b0) begin
        record_mismatch("full_ready", 0, miss_ready_i);
      end

      if (have_prev) begin
        if (prev_req && !prev_ack && !mem_req_i) begin
          flag_failure("mem_req_o fell before mem_ack_i was seen high");
        end
        if (!prev_req && mem_req_i && prev_ack) begin
          flag_failure("mem_req_o rose while mem_ack_i was still high");
        end
        if (prev_req && mem_req_i && mem_block_i !== prev_block) begin
          record_mismatch("mem_block_stable", prev_block, mem_block_i);
        end
        if (prev_resp_v && !prev_resp_ready) begin
          if (!resp_v_i) begin
            flag_failure("resp_v_o dropped while resp_ready_i was low");
          end
          if (resp_id_i !== prev_resp_id) begin
            record_mismatch("resp_id_stable", prev_resp_id, resp_id_i);
          end
          if (resp_data_i !== prev_resp_data) begin
            record_mismatch("resp_data_stable", prev_resp_data, resp_data_i);
          end
        end
        if (!prev_req && mem_req_i) begin
          check_request();
        end
        if (!prev_ack && mem_ack_i && mem_req_i) begin
          have_refill = 1'b1;
          last_block  = mem_block_i;
          ack_seq     = seq_cnt;
        end
      end

      if (resp_v_i && resp_ready_i) begin
        if (!out_v[resp_id_i]) begin
          flag_failure($sformatf("response for id %0d which has no outstanding miss",
                                 resp_id_i));
        end else begin
          exp_word = {out_block[resp_id_i], 16'(out_offset[resp_id_i])};
          if (resp_data_i !== exp_word) begin
            record_mismatch("resp_data", exp_word, resp_data_i);
          end
          for (i = 0; i < ids_lp; i++) begin
            if (out_v[i] && out_block[i] == out_block[resp_id_i] &&
                out_seq[i] < out_seq[resp_id_i]) begin
              flag_failure($sformatf("id %0d answered before older id %0d to the same block",
                                     resp_id_i, i));
            end
          end
          out_v[resp_id_i] = 1'b0;
          outstanding_o--;
        end
      end

      if (miss_v_i && miss_ready_i) begin
        out_v[miss_id_i]      = 1'b1;
        out_block[miss_id_i]  = miss_block_i;
        out_offset[miss_id_i] = miss_offset_i;
        out_seq[miss_id_i]    = seq_cnt;
        seq_cnt++;
        outstanding_o++;
      end

      if (final_check_i) begin
        for (i = 0; i < ids_lp; i++) begin
          if (out_v[i]) begin
            flag_failure($sformatf("no response arrived for id %0d", i));
          end
        end
      end

      have_prev       = 1'b1;
      prev_req        = mem_req_i;
      prev_ack        = mem_ack_i;
      prev_block      = mem_block_i;
      prev_resp_v     = resp_v_i;
      prev_resp_ready = resp_ready_i;
      prev_resp_id    = resp_id_i;
      prev_resp_data  = resp_data_i;
    end
  end

endmodule

// File: test/tb_miss_unit.sv
/*
 * Testbench for the miss unit.
 * Drives random load misses from a small block pool, models memory with
 * a four-phase ack after a random delay and consumes responses with
 * random back-pressure. All inputs change on the falling clock edge.
 * The checker module compares and this top reports the result.
 */
`include "miss_queue_macros.svh"

module tb_miss_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ids_lp     = 1 << `MQ_ID_W;
  localparam int traffic_lp = 400;

  logic                    clk;
  // active low
  logic                    reset_n;
  logic                    miss_v;
  logic                    miss_ready;
  logic [`MQ_BLOCK_W-1:0]  miss_block;
  logic [`MQ_OFFSET_W-1:0] miss_offset;
  logic [`MQ_ID_W-1:0]     miss_id;
  logic                    mem_req;
  logic [`MQ_BLOCK_W-1:0]  mem_block;
  logic                    mem_ack;
  logic [`MQ_LINE_W-1:0]   mem_line;
  logic                    resp_v;
  logic                    resp_ready;
  logic [`MQ_ID_W-1:0]     resp_id;
  logic [`MQ_WORD_W-1:0]   resp_data;

  logic [31:0]             rng;
  logic [`MQ_BLOCK_W-1:0]  block_pool [4];
  logic                    id_busy [ids_lp];
  int                      accepted_count;
  int                      miss_target;
  int                      ack_delay;
  logic                    mem_stall;
  logic                    final_check;
  int                      timeout_count;
  int                      outstanding;
  int                      mismatch_count;
  int                      failure_count;

  miss_unit miss_unit_inst (
    .clk_i        (clk),
    .reset_i      (reset_n),
    .miss_v_i     (miss_v),
    .miss_ready_o (miss_ready),
    .miss_block_i (miss_block),
    .miss_offset_i(miss_offset),
    .miss_id_i    (miss_id),
    .mem_req_o    (mem_req),
    .mem_block_o  (mem_block),
    .mem_ack_i    (mem_ack),
    .mem_line_i   (mem_line),
    .resp_v_o     (resp_v),
    .resp_ready_i (resp_ready),
    .resp_id_o    (resp_id),
    .resp_data_o  (resp_data)
  );

  miss_unit_checker checker_inst (
    .clk_i           (clk),
    .reset_i         (reset_n),
    .miss_v_i        (miss_v),
    .miss_ready_i    (miss_ready),
    .miss_block_i    (miss_block),
    .miss_offset_i   (miss_offset),
    .miss_id_i       (miss_id),
    .mem_req_i       (mem_req),
    .mem_block_i     (mem_block),
    .mem_ack_i       (mem_ack),
    .resp_v_i        (resp_v),
    .resp_ready_i    (resp_ready),
    .resp_id_i       (resp_id),
    .resp_data_i     (resp_data),
    .final_check_i   (final_check),
    .outstanding_o   (outstanding),
    .mismatch_count_o(mismatch_count),
    .failure_count_o (failure_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // word k holds the block address above k
  function automatic logic [`MQ_LINE_W-1:0] memory_line(input logic [`MQ_BLOCK_W-1:0] block);
    logic [`MQ_LINE_W-1:0] words;
    int                    k;
    for (k = 0; k < (1 << `MQ_OFFSET_W); k++) begin
      words[k*`MQ_WORD_W +: `MQ_WORD_W] = {block, 16'(k)};
    end
    return words;
  endfunction

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  // ids stay reserved from acceptance until their response transfers
  always @(posedge clk) begin
    int i;
    if (!reset_n) begin
      accepted_count <= 0;
      for (i = 0; i < ids_lp; i++) begin
        id_busy[i] <= 1'b0;
      end
    end else begin
      if (resp_v && resp_ready) begin
        id_busy[resp_id] <= 1'b0;
      end
      if (miss_v && miss_ready) begin
        id_busy[miss_id] <= 1'b1;
        accepted_count   <= accepted_count + 1;
      end
    end
  end

  task automatic drive_inputs();
    logic [31:0] r;
    int          k;
    int          cand;
    int          pick;
    rng  = xorshift32(rng);
    r    = rng;
    pick = -1;
    if (accepted_count < miss_target && r[1:0] != 2'b00) begin
      for (k = 0; k < ids_lp; k++) begin
        cand = (int'(r[7:4]) + k) % ids_lp;
        if (pick < 0 && !id_busy[cand]) begin
          pick = cand;
        end
      end
    end
    miss_v = (pick >= 0);
    if (pick >= 0) begin
      miss_id     = `MQ_ID_W'(pick);
      miss_block  = block_pool[r[9:8]];
      miss_offset = r[11:10];
    end

    // memory side of the four-phase handshake
    rng = xorshift32(rng);
    r   = rng;
    if (mem_req && !mem_ack && !mem_stall) begin
      if (ack_delay == 0) begin
        mem_ack  = 1'b1;
        mem_line = memory_line(mem_block);
      end else begin
        ack_delay--;
      end
    end else if (mem_ack && !mem_req) begin
      mem_ack   = 1'b0;
      ack_delay = int'(r[2:0]);
    end
    resp_ready = (r[5:4] != 2'b00);
  endtask

  task automatic tick();
    @(negedge clk);
    drive_inputs();
  endtask

  initial begin
    int waited;
    rng           = 32'hb258;
    block_pool    = '{16'h0040, 16'h1a2c, 16'h7f00, 16'hc3b5};
    reset_n       = 1'b0;
    miss_v        = 1'b0;
    miss_block    = '0;
    miss_offset   = '0;
    miss_id       = '0;
    mem_ack       = 1'b0;
    mem_line      = '0;
    resp_ready    = 1'b0;
    mem_stall     = 1'b1;
    miss_target   = 0;
    ack_delay     = 2;
    final_check   = 1'b0;
    timeout_count = 0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;

    // fill the FIFO behind a refill that memory holds back
    miss_target = `MQ_ELS;
    waited      = 0;
    while (accepted_count < `MQ_ELS && waited < 200) begin
      tick();
      waited++;
    end
    if (accepted_count < `MQ_ELS) begin
      report_timeout("the FIFO did not take eight misses during the stalled refill");
    end
    repeat (8) tick();

    mem_stall   = 1'b0;
    miss_target = `MQ_ELS + traffic_lp;
    waited      = 0;
    while (accepted_count < miss_target && waited < 50000) begin
      tick();
      waited++;
    end
    if (accepted_count < miss_target) begin
      report_timeout("the DUT stopped accepting misses");
    end

    waited = 0;
    while (outstanding != 0 && waited < 5000) begin
      tick();
      waited++;
    end
    if (outstanding != 0) begin
      report_timeout("outstanding misses never got their responses");
    end

    final_check = 1'b1;
    tick();
    final_check = 1'b0;
    tick();
    tick();

    $display("mismatches=%0d failures=%0d timeouts=%0d",
             mismatch_count, failure_count, timeout_count);
    if (mismatch_count == 0 && failure_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/miss_queue_pkg.sv
src/miss_fifo.sv
src/refill_requester.sv
src/miss_replay_ctrl.sv
src/miss_unit.sv
test/miss_unit_checker.sv
test/tb_miss_unit.sv
